// ==== pcie_msi_pkg.sv ====
//************************************************
// PCIe endpoint MSI test package
// AXI bus widths, channel structs, response
// constants and the byte parity function
//************************************************
package pcie_msi_pkg;

    // bus widths
    parameter int ADDR_W     = 64;
    parameter int DATA_W     = 256;
    parameter int STRB_W     = DATA_W / 8;
    parameter int ID_W       = 8;
    parameter int USER_W     = 88;
    parameter int MSI_ADDR_W = 32;
    parameter int MSI_DATA_W = 16;

    // response codes and fixed target ids
    parameter logic [1:0]      RESP_OKAY = 2'b00;
    parameter logic [ID_W-1:0] TGT_BID   = 8'hFF;
    parameter logic [ID_W-1:0] TGT_RID   = 8'h00;

    //************************************************
    // channel payloads
    //************************************************
    // shared by AW and AR
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [USER_W-1:0] user;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   data_par;
        logic [STRB_W-1:0]   strb;
        logic [STRB_W/8-1:0] strb_par;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            id_par;
        logic [1:0]      resp;
        logic            resp_par;
    } axi_b_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] data_par;
        logic [ID_W-1:0]   id;
        logic              id_par;
        logic [1:0]        resp;
        logic              resp_par;
        logic              last;
    } axi_r_t;

    // odd parity, one bit per byte
    // shorter fields are zero-extended, so bit 0 covers a field of up to 8 bits
    function automatic logic [STRB_W-1:0] byte_par(input logic [DATA_W-1:0] v);
        logic [STRB_W-1:0] p;
        for (int i = 0; i < STRB_W; i++) begin
            p[i] = ~(^v[i*8 +: 8]);
        end
        return p;
    endfunction

endpackage

// ==== target_responder.sv ====
//************************************************
// target-side AXI responder
// answers writes with a B pulse and reads with a
// single-beat R pulse, read data is the last write
//************************************************
`timescale 1ns/100ps

module target_responder (
    input  logic                      axiclk,
    input  logic                      MSI_TEST_INIT,
    input  pcie_msi_pkg::axi_addr_t   tgt_ar_i,
    input  logic                      tgt_arvalid_i,
    input  pcie_msi_pkg::axi_w_t      tgt_w_i,
    input  logic                      tgt_wvalid_i,
    output pcie_msi_pkg::axi_b_t      tgt_b_o,
    output logic                      tgt_bvalid_o,
    output pcie_msi_pkg::axi_r_t      tgt_r_o,
    output logic                      tgt_rvalid_o
);
    import pcie_msi_pkg::*;

    logic [DATA_W-1:0] last_wdata;
    logic [DATA_W-1:0] rdata_q;
    logic              rlast_q;
    logic [STRB_W-1:0] bid_par_w;
    logic [STRB_W-1:0] rid_par_w;
    logic [STRB_W-1:0] resp_par_w;

    //************************************************
    // response pulses and data capture
    //************************************************
    always_ff @(posedge axiclk or negedge MSI_TEST_INIT) begin
        if (!MSI_TEST_INIT) begin
            tgt_bvalid_o <= 1'b0;
            tgt_rvalid_o <= 1'b0;
            rlast_q      <= 1'b0;
            last_wdata   <= '0;
            rdata_q      <= '0;
        end else begin
            // one B per last beat
            tgt_bvalid_o <= tgt_wvalid_i & tgt_w_i.last;
            tgt_rvalid_o <= tgt_arvalid_i;
            rlast_q      <= tgt_arvalid_i;
            if (tgt_wvalid_i) begin
                last_wdata <= tgt_w_i.data;
            end
            // snapshot before a write in the same cycle lands
            if (tgt_arvalid_i) begin
                rdata_q <= last_wdata;
            end
        end
    end

    //************************************************
    // channel payloads with parity
    //************************************************
    assign bid_par_w  = byte_par(TGT_BID);
    assign rid_par_w  = byte_par(TGT_RID);
    assign resp_par_w = byte_par(RESP_OKAY);

    always_comb begin
        tgt_b_o.id       = TGT_BID;
        tgt_b_o.id_par   = bid_par_w[0];
        tgt_b_o.resp     = RESP_OKAY;
        tgt_b_o.resp_par = resp_par_w[0];
    end

    always_comb begin
        tgt_r_o.data     = rdata_q;
        tgt_r_o.data_par = byte_par(rdata_q);
        tgt_r_o.id       = TGT_RID;
        tgt_r_o.id_par   = rid_par_w[0];
        tgt_r_o.resp     = RESP_OKAY;
        tgt_r_o.resp_par = resp_par_w[0];
        tgt_r_o.last     = rlast_q;
    end

    // every read is a single beat
    a_rlast_with_rvalid: assert property (
        @(posedge axiclk) disable iff (!MSI_TEST_INIT)
        tgt_r_o.last == tgt_rvalid_o
    );

endmodule

// ==== write_seq_checker.sv ====
//************************************************
// write data sequence checker
// counts breaks in an incrementing 16-bit pattern
//************************************************
`timescale 1ns/100ps

module write_seq_checker #(
    parameter int CNT_W = 16
) (
    input  logic             axiclk,
    input  logic             MSI_TEST_INIT,
    input  logic [15:0]      seq_word_i,
    input  logic             seq_valid_i,
    output logic [CNT_W-1:0] err_count_o
);

    logic        seeded;
    logic [15:0] prev_word;
    logic        seq_break;

    // wraps at 16 bits
    assign seq_break = seeded && (seq_word_i != prev_word + 16'd1);

    always_ff @(posedge axiclk or negedge MSI_TEST_INIT) begin
        if (!MSI_TEST_INIT) begin
            seeded      <= 1'b0;
            prev_word   <= '0;
            err_count_o <= '0;
        end else if (seq_valid_i) begin
            // first beat only seeds the pattern
            seeded    <= 1'b1;
            prev_word <= seq_word_i;
            // saturate at all ones
            if (seq_break && !(&err_count_o)) begin
                err_count_o <= err_count_o + 1'b1;
            end
        end
    end

    a_count_monotonic: assert property (
        @(posedge axiclk) disable iff (!MSI_TEST_INIT)
        err_count_o >= $past(err_count_o)
    );

endmodule

// ==== msi_trigger_timer.sv ====
//************************************************
// MSI test trigger timer
// free-running counter, one trigger pulse per wrap
//************************************************
`timescale 1ns/100ps

module msi_trigger_timer #(
    parameter int CNT_W = 8
) (
    input  logic axiclk,
    input  logic MSI_TEST_INIT,
    output logic msi_trig_o
);

    logic [CNT_W-1:0] cnt;
    logic             top_q;

    always_ff @(posedge axiclk or negedge MSI_TEST_INIT) begin
        if (!MSI_TEST_INIT) begin
            cnt        <= '0;
            top_q      <= 1'b0;
            msi_trig_o <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;
            top_q <= cnt[CNT_W-1];
            // rising edge of the top bit
            msi_trig_o <= cnt[CNT_W-1] & ~top_q;
        end
    end

endmodule

// ==== msi_write_master.sv ====
//************************************************
// single-beat MSI write master
// issues one AXI write of the MSI data word for
// each start taken while idle
//************************************************
`timescale 1ns/100ps

module msi_write_master (
    input  logic                                axiclk,
    input  logic                                MSI_TEST_INIT,
    input  logic                                msi_trig_i,
    input  logic                                msi_start_i,
    input  logic [pcie_msi_pkg::MSI_ADDR_W-1:0] msi_addr_i,
    input  logic [pcie_msi_pkg::MSI_DATA_W-1:0] msi_data_i,
    output pcie_msi_pkg::axi_addr_t             mst_aw_o,
    output logic                                mst_awvalid_o,
    input  logic                                mst_awready_i,
    output pcie_msi_pkg::axi_w_t                mst_w_o,
    output logic                                mst_wvalid_o,
    input  logic                                mst_wready_i,
    input  pcie_msi_pkg::axi_b_t                mst_b_i,
    input  logic                                mst_bvalid_i,
    output logic                                mst_bready_o,
    output logic                                msi_busy_o
);
    import pcie_msi_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_RESP
    } state_t;

    state_t                state;
    logic [MSI_ADDR_W-1:0] addr_q;
    logic [MSI_DATA_W-1:0] data_q;
    logic [2:0]            lane;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic [STRB_W-1:0]     strb_par_w;
    logic                  aw_pend;
    logic                  w_pend;

    //************************************************
    // payloads from the captured message
    //************************************************
    // 32-bit lane picked by address bits 4:2
    assign lane       = addr_q[4:2];
    assign wdata      = DATA_W'(data_q) << (lane * 32);
    assign wstrb      = STRB_W'(4'hF) << (lane * 4);
    assign strb_par_w = byte_par(wstrb);

    always_comb begin
        mst_aw_o.addr = ADDR_W'(addr_q);
        mst_aw_o.id   = '0;
        mst_aw_o.len  = 8'd0;
        mst_aw_o.size = 3'd2;
        mst_aw_o.user = '0;
    end

    always_comb begin
        mst_w_o.data     = wdata;
        mst_w_o.data_par = byte_par(wdata);
        mst_w_o.strb     = wstrb;
        mst_w_o.strb_par = strb_par_w[STRB_W/8-1:0];
        mst_w_o.last     = 1'b1;
    end

    //************************************************
    // request FSM
    //************************************************
    // still waiting after this cycle
    assign aw_pend = mst_awvalid_o & ~mst_awready_i;
    assign w_pend  = mst_wvalid_o & ~mst_wready_i;

    always_ff @(posedge axiclk or negedge MSI_TEST_INIT) begin
        if (!MSI_TEST_INIT) begin
            state         <= ST_IDLE;
            addr_q        <= '0;
            data_q        <= '0;
            mst_awvalid_o <= 1'b0;
            mst_wvalid_o  <= 1'b0;
            mst_bready_o  <= 1'b0;
            msi_busy_o    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (msi_trig_i || msi_start_i) begin
                        addr_q        <= msi_addr_i;
                        data_q        <= msi_data_i;
                        mst_awvalid_o <= 1'b1;
                        mst_wvalid_o  <= 1'b1;
                        msi_busy_o    <= 1'b1;
                        state         <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    // AW and W complete independently
                    mst_awvalid_o <= aw_pend;
                    mst_wvalid_o  <= w_pend;
                    if (!aw_pend && !w_pend) begin
                        mst_bready_o <= 1'b1;
                        state        <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (mst_bvalid_i) begin
                        mst_bready_o <= 1'b0;
                        msi_busy_o   <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //************************************************
    // protocol checks
    //************************************************
    a_aw_stable: assert property (
        @(posedge axiclk) disable iff (!MSI_TEST_INIT)
        mst_awvalid_o && !mst_awready_i |=> mst_awvalid_o && $stable(mst_aw_o)
    );

    a_w_stable: assert property (
        @(posedge axiclk) disable iff (!MSI_TEST_INIT)
        mst_wvalid_o && !mst_wready_i |=> mst_wvalid_o && $stable(mst_w_o)
    );

    a_bready_alone: assert property (
        @(posedge axiclk) disable iff (!MSI_TEST_INIT)
        mst_bready_o |-> !mst_awvalid_o && !mst_wvalid_o
    );

    // the completing response from the PCIe side is OKAY
    a_resp_okay: assert property (
        @(posedge axiclk) disable iff (!MSI_TEST_INIT)
        mst_bvalid_i && mst_bready_o |-> mst_b_i.resp == RESP_OKAY
    );

endmodule

// ==== pcie_msi_top.sv ====
//************************************************
// PCIe endpoint MSI test top
// target responder, write sequence checker, MSI
// trigger timer and MSI write master
//************************************************
`timescale 1ns/100ps

module pcie_msi_top #(
    parameter int TRIG_CNT_W = 8,
    parameter int ERR_CNT_W  = 16
) (
    input  logic                                axiclk,
    input  logic                                MSI_TEST_INIT,
    // target side, PCIe to fabric
    input  pcie_msi_pkg::axi_addr_t             tgt_aw_i,
    input  logic                                tgt_awvalid_i,
    input  pcie_msi_pkg::axi_addr_t             tgt_ar_i,
    input  logic                                tgt_arvalid_i,
    input  pcie_msi_pkg::axi_w_t                tgt_w_i,
    input  logic                                tgt_wvalid_i,
    output pcie_msi_pkg::axi_b_t                tgt_b_o,
    output logic                                tgt_bvalid_o,
    output pcie_msi_pkg::axi_r_t                tgt_r_o,
    output logic                                tgt_rvalid_o,
    output logic [ERR_CNT_W-1:0]                err_count_o,
    // MSI message
    input  logic [pcie_msi_pkg::MSI_ADDR_W-1:0] msi_addr_i,
    input  logic [pcie_msi_pkg::MSI_DATA_W-1:0] msi_data_i,
    input  logic                                msi_start_i,
    // master side, fabric to PCIe
    output pcie_msi_pkg::axi_addr_t             mst_aw_o,
    output logic                                mst_awvalid_o,
    output pcie_msi_pkg::axi_w_t                mst_w_o,
    output logic                                mst_wvalid_o,
    input  logic                                mst_awready_i,
    input  logic                                mst_wready_i,
    input  pcie_msi_pkg::axi_b_t                mst_b_i,
    input  logic                                mst_bvalid_i,
    output logic                                mst_bready_o,
    output logic                                msi_busy_o
);

    logic msi_trig;

    target_responder u_responder (
        .axiclk        (axiclk),
        .MSI_TEST_INIT (MSI_TEST_INIT),
        .tgt_ar_i      (tgt_ar_i),
        .tgt_arvalid_i (tgt_arvalid_i),
        .tgt_w_i       (tgt_w_i),
        .tgt_wvalid_i  (tgt_wvalid_i),
        .tgt_b_o       (tgt_b_o),
        .tgt_bvalid_o  (tgt_bvalid_o),
        .tgt_r_o       (tgt_r_o),
        .tgt_rvalid_o  (tgt_rvalid_o)
    );

    // pattern lives in the low word of each beat
    write_seq_checker #(
        .CNT_W (ERR_CNT_W)
    ) u_seq_checker (
        .axiclk        (axiclk),
        .MSI_TEST_INIT (MSI_TEST_INIT),
        .seq_word_i    (tgt_w_i.data[15:0]),
        .seq_valid_i   (tgt_wvalid_i),
        .err_count_o   (err_count_o)
    );

    msi_trigger_timer #(
        .CNT_W (TRIG_CNT_W)
    ) u_trig_timer (
        .axiclk        (axiclk),
        .MSI_TEST_INIT (MSI_TEST_INIT),
        .msi_trig_o    (msi_trig)
    );

    msi_write_master u_msi_master (
        .axiclk        (axiclk),
        .MSI_TEST_INIT (MSI_TEST_INIT),
        .msi_trig_i    (msi_trig),
        .msi_start_i   (msi_start_i),
        .msi_addr_i    (msi_addr_i),
        .msi_data_i    (msi_data_i),
        .mst_aw_o      (mst_aw_o),
        .mst_awvalid_o (mst_awvalid_o),
        .mst_awready_i (mst_awready_i),
        .mst_w_o       (mst_w_o),
        .mst_wvalid_o  (mst_wvalid_o),
        .mst_wready_i  (mst_wready_i),
        .mst_b_i       (mst_b_i),
        .mst_bvalid_i  (mst_bvalid_i),
        .mst_bready_o  (mst_bready_o),
        .msi_busy_o    (msi_busy_o)
    );

endmodule

// ==== tb_pcie_msi_top.sv ====
//**************************************************
// testbench for the PCIe MSI test top
// target side, trigger timer and MSI master checks
//**************************************************
`timescale 1ns/100ps

module tb_pcie_msi_top;
    import pcie_msi_pkg::*;

    // B and R tags with single-group odd parity
    localparam axi_b_t      B_EXP     = {8'hFF, ~^8'hFF, 2'b00, ~^2'b00};
    localparam logic [11:0] R_TAG_EXP = {8'h00, ~^8'h00, 2'b00, ~^2'b00};

    logic axiclk;
    logic MSI_TEST_INIT;
    axi_addr_t tgt_aw_i, tgt_ar_i, mst_aw_o;
    logic tgt_awvalid_i, tgt_arvalid_i, tgt_wvalid_i, tgt_bvalid_o, tgt_rvalid_o;
    axi_w_t tgt_w_i, mst_w_o;
    axi_b_t tgt_b_o, mst_b_i;
    axi_r_t tgt_r_o;
    logic [15:0] err_count_o;
    logic [31:0] msi_addr_i;
    logic [15:0] msi_data_i;
    logic msi_start_i, mst_awvalid_o, mst_wvalid_o, mst_awready_i, mst_wready_i;
    logic mst_bvalid_i, mst_bready_o, msi_busy_o;

    logic [31:0] lfsr = 32'd93796;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_at_start;
    int cyc = 0;
    string cur_test = "reset";
    logic [31:0] exp_addr;
    logic [15:0] exp_data, last_word;
    logic [255:0] wdata_model, rd_exp;
    int aw_count = 0;
    int w_count = 0;
    int aw_rises[$];
    logic aw_seen = 1'b0;

    pcie_msi_top dut (.*);

    always #10 axiclk = ~axiclk;

    // one random bit per LFSR step with taps x^32+x^22+x^2+x+1
    function automatic logic [255:0] rand_bits(input int n);
        logic [255:0] v = '0;
        logic fb;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v[i] = fb;
        end
        return v;
    endfunction

    function automatic logic [31:0] odd_par(input logic [255:0] v);
        logic [31:0] p;
        for (int b = 0; b < 32; b++) begin
            p[b] = ~(^v[b*8 +: 8]);
        end
        return p;
    endfunction

    task automatic fail(input string what);
        errors++;
        $display("%s", what);
    endtask

    //**************************************************
    // timing and field checks
    //**************************************************
    a_b_timing: assert property (@(posedge axiclk) disable iff (!MSI_TEST_INIT)
        tgt_bvalid_o == $past(tgt_wvalid_i && tgt_w_i.last))
        else fail($sformatf("%s: write response pulse not one cycle after last beat", cur_test));
    a_r_timing: assert property (@(posedge axiclk) disable iff (!MSI_TEST_INIT)
        tgt_rvalid_o == $past(tgt_arvalid_i) && tgt_r_o.last == tgt_rvalid_o)
        else fail($sformatf("%s: read pulse or last bit not one cycle after address", cur_test));
    a_b_fields: assert property (@(posedge axiclk) disable iff (!MSI_TEST_INIT)
        tgt_bvalid_o |-> tgt_b_o == B_EXP)
        else fail($sformatf("MISMATCH %s b exp %h act %h", cur_test, B_EXP, tgt_b_o));
    a_r_fields: assert property (@(posedge axiclk) disable iff (!MSI_TEST_INIT)
        tgt_rvalid_o |-> {tgt_r_o.id, tgt_r_o.id_par, tgt_r_o.resp, tgt_r_o.resp_par} == R_TAG_EXP)
        else fail($sformatf("MISMATCH %s r tag exp %h act %h", cur_test, R_TAG_EXP,
                            {tgt_r_o.id, tgt_r_o.id_par, tgt_r_o.resp, tgt_r_o.resp_par}));
    a_busy_end: assert property (@(posedge axiclk) disable iff (!MSI_TEST_INIT)
        mst_bvalid_i && mst_bready_o |=> !msi_busy_o)
        else fail($sformatf("%s: busy still high after response handshake", cur_test));

    // a read returns the last write before its own cycle
    always @(posedge axiclk) begin
        if (MSI_TEST_INIT) begin
            cyc <= cyc + 1;
            if (tgt_rvalid_o) begin
                assert (tgt_r_o.data == rd_exp && tgt_r_o.data_par == odd_par(rd_exp))
                    else fail($sformatf("MISMATCH %s rdata exp %h act %h", cur_test,
                                        rd_exp, tgt_r_o.data));
            end
            if (tgt_arvalid_i) rd_exp <= wdata_model;
            if (tgt_wvalid_i) wdata_model <= tgt_w_i.data;
            if (mst_awvalid_o && !aw_seen) aw_rises.push_back(cyc);
            aw_seen <= mst_awvalid_o;
        end
    end

    //**************************************************
    // slave model for the master side
    //**************************************************
    initial begin
        logic aw_hs, w_hs, b_hs, aw_got, w_got;
        logic [1:0] aw_dly, w_dly;
        logic [255:0] wd;
        logic [31:0] ws;
        logic [31:0] wsp;
        axi_addr_t aw_exp;
        axi_w_t w_exp;
        aw_got = 0;
        w_got = 0;
        aw_dly = rand_bits(2);
        w_dly = rand_bits(2);
        mst_awready_i = 0;
        mst_wready_i = 0;
        mst_bvalid_i = 0;
        mst_b_i = {8'h00, 1'b1, RESP_OKAY, 1'b1};
        forever begin
            @(posedge axiclk);
            aw_hs = mst_awvalid_o && mst_awready_i;
            w_hs = mst_wvalid_o && mst_wready_i;
            b_hs = mst_bvalid_i && mst_bready_o;
            if (aw_hs) begin
                aw_count++;
                aw_got = 1;
                aw_exp = {32'd0, exp_addr, 8'd0, 8'd0, 3'd2, 88'd0};
                assert (mst_aw_o == aw_exp)
                    else fail($sformatf("MISMATCH %s aw exp %h act %h", cur_test,
                                        aw_exp, mst_aw_o));
            end
            if (w_hs) begin
                w_count++;
                w_got = 1;
                wd = '0;
                wd[exp_addr[4:2]*32 +: 16] = exp_data;
                for (int b = 0; b < 32; b++) ws[b] = (b / 4 == exp_addr[4:2]);
                wsp = odd_par(ws);
                w_exp = {wd, odd_par(wd), ws, wsp[3:0], 1'b1};
                assert (mst_w_o == w_exp)
                    else fail($sformatf("MISMATCH %s w exp %h act %h", cur_test,
                                        w_exp, mst_w_o));
            end
            #2;
            if (aw_hs) begin
                mst_awready_i = 0;
                aw_dly = rand_bits(2);
            end else if (mst_awvalid_o) begin
                if (aw_dly == 0) mst_awready_i = 1;
                else aw_dly--;
            end
            if (w_hs) begin
                mst_wready_i = 0;
                w_dly = rand_bits(2);
            end else if (mst_wvalid_o) begin
                if (w_dly == 0) mst_wready_i = 1;
                else w_dly--;
            end
            if (b_hs) begin
                mst_bvalid_i = 0;
                aw_got = 0;
                w_got = 0;
            end else if (aw_got && w_got) begin
                mst_bvalid_i = 1;
            end
        end
    end

    //**************************************************
    // stimulus tasks
    //**************************************************
    task automatic send_beat(input logic [15:0] word, input logic last, input logic rd);
        @(posedge axiclk);
        #2;
        tgt_w_i = '0;
        tgt_w_i.data = {rand_bits(240), word};
        tgt_w_i.last = last;
        tgt_wvalid_i = 1;
        tgt_awvalid_i = last;
        tgt_arvalid_i = rd;
        last_word = word;
        @(posedge axiclk);
        #2;
        tgt_wvalid_i = 0;
        tgt_awvalid_i = 0;
        tgt_arvalid_i = 0;
    endtask

    task automatic wait_busy(input string what, input int limit, input logic val);
        int n = 0;
        while (msi_busy_o !== val) begin
            @(posedge axiclk);
            #2;
            n++;
            if (n > limit) begin
                $display("timeout waiting for %s in %s", what, cur_test);
                $display("Checks failed");
                $finish;
            end
        end
    endtask

    task automatic wait_until_cycle(input int target);
        int n = 0;
        while (cyc < target) begin
            @(posedge axiclk);
            #2;
            n++;
            if (n > 1000) begin
                $display("timeout waiting for cycle %0d", target);
                $display("Checks failed");
                $finish;
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == err_at_start) begin
            $display("%s: PASS", cur_test);
        end else begin
            $display("%s: FAIL", cur_test);
            tests_failed++;
        end
    endtask

    //**************************************************
    // test sequence
    //**************************************************
    initial begin
        int base;
        int breaks;
        int aw_before;
        logic [15:0] w;
        logic [21:0] rst_vals;
        axiclk = 0;
        MSI_TEST_INIT = 0;
        tgt_aw_i = '0;
        tgt_ar_i = '0;
        tgt_w_i = '0;
        tgt_awvalid_i = 0;
        tgt_arvalid_i = 0;
        tgt_wvalid_i = 0;
        msi_start_i = 0;
        msi_addr_i = 32'hFEE0_0014;
        msi_data_i = 16'h4021;
        exp_addr = msi_addr_i;
        exp_data = msi_data_i;
        wdata_model = '0;
        rd_exp = '0;
        repeat (8) @(posedge axiclk);
        #2;
        MSI_TEST_INIT = 1;

        begin_test("reset_values");
        rst_vals = {tgt_bvalid_o, tgt_rvalid_o, mst_awvalid_o, mst_wvalid_o, mst_bready_o,
                    msi_busy_o, err_count_o};
        assert (rst_vals == '0)
            else fail($sformatf("MISMATCH %s outputs exp %h act %h", cur_test,
                                22'd0, rst_vals));
        end_test();

        begin_test("write_response");
        send_beat(16'h0100, 1'b0, 1'b0);
        send_beat(16'h0101, 1'b1, 1'b0);
        repeat (3) @(posedge axiclk);
        end_test();

        begin_test("read_back");
        send_beat(16'h0102, 1'b1, 1'b0);
        send_beat(16'h0103, 1'b1, 1'b1);
        send_beat(16'h0104, 1'b0, 1'b1);
        repeat (3) @(posedge axiclk);
        end_test();

        begin_test("seq_breaks");
        base = err_count_o;
        breaks = 0;
        w = last_word;
        for (int i = 0; i < 24; i++) begin
            w = (i % 7 == 3) ? w + 16'd7 : w + 16'd1;
            if (i % 7 == 3) breaks++;
            send_beat(w, i[0], 1'b0);
        end
        @(posedge axiclk);
        #2;
        assert (err_count_o == base + breaks)
            else fail($sformatf("MISMATCH %s err_count exp %0d act %0d", cur_test,
                                base + breaks, err_count_o));
        end_test();

        begin_test("msi_manual");
        wait_busy("first auto write", 300, 1'b1);
        wait_busy("first auto write end", 50, 1'b0);
        wait_until_cycle(160);
        msi_addr_i = rand_bits(32);
        msi_data_i = rand_bits(16);
        exp_addr = msi_addr_i;
        exp_data = msi_data_i;
        aw_before = aw_count;
        msi_start_i = 1;
        @(posedge axiclk);
        #2;
        msi_start_i = 0;
        wait_busy("busy", 10, 1'b1);
        msi_start_i = 1;
        @(posedge axiclk);
        #2;
        msi_start_i = 0;
        wait_busy("busy end", 50, 1'b0);
        repeat (4) @(posedge axiclk);
        #2;
        assert (aw_count == aw_before + 1 && w_count == aw_count)
            else fail($sformatf("MISMATCH %s transfers exp %0d act %0d", cur_test,
                                aw_before + 1, aw_count));
        end_test();

        begin_test("msi_timer");
        wait_until_cycle(400);
        assert (aw_rises.size() == 3)
            else fail($sformatf("MISMATCH %s aw rises exp %0d act %0d", cur_test,
                                3, aw_rises.size()));
        assert (aw_rises[0] == 130)
            else fail($sformatf("MISMATCH %s first rise exp %0d act %0d", cur_test,
                                130, aw_rises[0]));
        assert (aw_rises[2] == 130 + 256)
            else fail($sformatf("MISMATCH %s next timer rise exp %0d act %0d", cur_test,
                                130 + 256, aw_rises[2]));
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
pcie_msi_pkg.sv
target_responder.sv
write_seq_checker.sv
msi_trigger_timer.sv
msi_write_master.sv
pcie_msi_top.sv
tb_pcie_msi_top.sv
